//--- hdl/mcu_macros.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU subsystem widths and sizes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

`define MCU_DATA_W 32
`define MCU_ADDR_W 8
`define MCU_MEM_WORDS (1 << `MCU_ADDR_W)

// command word fields
`define MCU_OP_W 4
`define MCU_RSVD_W 4
`define MCU_IMM_W 16

// heartbeat counter, short for simulation
`define MCU_LED_CNT_W 6

// set to 1'b1 for a board with an active-low reset button
`define MCU_BOARD_RST_LOW 1'b0

`endif

//--- hdl/mcu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU package: command encoding and memory word views
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mcu_macros.svh"

package mcu_pkg;

  typedef enum logic [`MCU_OP_W-1:0] {
    CMD_NOP   = 4'h0,
    CMD_WRITE = 4'h1,
    CMD_ADD   = 4'h2,
    CMD_EXIT  = 4'h3
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e                 op;
    logic [`MCU_RSVD_W-1:0]  rsvd;
    logic [`MCU_ADDR_W-1:0]  addr;
    logic [`MCU_IMM_W-1:0]   imm;
  } cmd_word_t;

  // one memory word, seen as data or as a command
  typedef union packed {
    logic [`MCU_DATA_W-1:0]  raw;
    cmd_word_t               cmd;
  } mem_word_u;

  typedef enum logic {
    MST_LOADER = 1'b0,
    MST_ENGINE = 1'b1
  } master_e;

endpackage

`default_nettype wire

//--- hdl/mem_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter between host loader and command engine
// Grants one master per cycle, steers read data back to its owner
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "mcu_macros.svh"

module mem_arbiter (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  logic                   ldr_req_i,
  input  logic                   ldr_we_i,
  input  logic [`MCU_ADDR_W-1:0] ldr_addr_i,
  input  logic [`MCU_DATA_W-1:0] ldr_wdata_i,
  output logic                   ldr_gnt_o,
  output logic                   ldr_rvalid_o,
  output logic [`MCU_DATA_W-1:0] ldr_rdata_o,
  input  logic                   eng_req_i,
  input  logic                   eng_we_i,
  input  logic [`MCU_ADDR_W-1:0] eng_addr_i,
  input  logic [`MCU_DATA_W-1:0] eng_wdata_i,
  output logic                   eng_gnt_o,
  output logic                   eng_rvalid_o,
  output logic [`MCU_DATA_W-1:0] eng_rdata_o,
  output logic                   mem_en_o,
  output logic                   mem_we_o,
  output logic [`MCU_ADDR_W-1:0] mem_addr_o,
  output logic [`MCU_DATA_W-1:0] mem_wdata_o,
  input  logic [`MCU_DATA_W-1:0] mem_rdata_i
);
  import mcu_pkg::*;

  master_e last_q;
  master_e owner_q;
  logic    rd_pend_q;

  // on a tie the master not served last wins
  always_comb begin
    ldr_gnt_o = 1'b0;
    eng_gnt_o = 1'b0;
    if (ldr_req_i && eng_req_i) begin
      if (last_q == MST_LOADER) begin
        eng_gnt_o = 1'b1;
      end else begin
        ldr_gnt_o = 1'b1;
      end
    end else begin
      ldr_gnt_o = ldr_req_i;
      eng_gnt_o = eng_req_i;
    end
  end

  assign mem_en_o    = ldr_gnt_o | eng_gnt_o;
  assign mem_we_o    = eng_gnt_o ? eng_we_i : (ldr_gnt_o & ldr_we_i);
  assign mem_addr_o  = eng_gnt_o ? eng_addr_i : ldr_addr_i;
  assign mem_wdata_o = eng_gnt_o ? eng_wdata_i : ldr_wdata_i;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      last_q    <= MST_ENGINE;
      owner_q   <= MST_LOADER;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_en_o & ~mem_we_o;
      if (mem_en_o) begin
        last_q  <= eng_gnt_o ? MST_ENGINE : MST_LOADER;
        owner_q <= eng_gnt_o ? MST_ENGINE : MST_LOADER;
      end
    end
  end

  // read return, one cycle after the grant
  assign ldr_rvalid_o = rd_pend_q & (owner_q == MST_LOADER);
  assign eng_rvalid_o = rd_pend_q & (owner_q == MST_ENGINE);
  assign ldr_rdata_o  = mem_rdata_i;
  assign eng_rdata_o  = mem_rdata_i;

endmodule

`default_nettype wire

//--- hdl/sram_bank.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous SRAM bank with registered read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "mcu_macros.svh"

module sram_bank (
  input  logic                   clk_gen,
  input  logic                   en_i,
  input  logic                   we_i,
  input  logic [`MCU_ADDR_W-1:0] addr_i,
  input  mcu_pkg::mem_word_u     wdata_i,
  output mcu_pkg::mem_word_u     rdata_o
);
  import mcu_pkg::*;

  mem_word_u mem_q [`MCU_MEM_WORDS];
  mem_word_u rdata_q;

  // read data only changes on a read access
  always_ff @(posedge clk_gen) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hdl/host_loader.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host load and readback port, one access held until granted
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "mcu_macros.svh"

module host_loader (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  logic                   load_we_i,
  input  logic                   load_rd_i,
  input  logic [`MCU_ADDR_W-1:0] load_addr_i,
  input  logic [`MCU_DATA_W-1:0] load_data_i,
  output logic                   busy_o,
  output logic                   rd_valid_o,
  output logic [`MCU_DATA_W-1:0] rd_data_o,
  output logic                   req_o,
  output logic                   we_o,
  output logic [`MCU_ADDR_W-1:0] addr_o,
  output logic [`MCU_DATA_W-1:0] wdata_o,
  input  logic                   gnt_i,
  input  logic                   rvalid_i,
  input  logic [`MCU_DATA_W-1:0] rdata_i
);

  logic                   busy_q;
  logic                   hold_we_q;
  logic [`MCU_ADDR_W-1:0] hold_addr_q;
  logic [`MCU_DATA_W-1:0] hold_data_q;
  logic                   accept;

  // write wins if both strobes come together
  assign accept = (load_we_i | load_rd_i) & ~busy_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (gnt_i) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_gen) begin
    if (accept) begin
      hold_we_q   <= load_we_i;
      hold_addr_q <= load_addr_i;
      hold_data_q <= load_data_i;
    end
  end

  assign busy_o  = busy_q;
  assign req_o   = busy_q;
  assign we_o    = hold_we_q;
  assign addr_o  = hold_addr_q;
  assign wdata_o = hold_data_q;

  // arbiter only returns reads that this port owns
  assign rd_valid_o = rvalid_i;
  assign rd_data_o  = rdata_i;

endmodule

`default_nettype wire

//--- hdl/cmd_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command engine: fetches command words from address 0 and executes them
// until an exit command or a program counter wrap
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "mcu_macros.svh"

module cmd_engine (
  input  logic                   clk_gen,
  input  logic                   rst_n,
  input  logic                   run_i,
  output logic                   running_o,
  output logic                   exit_valid_o,
  output logic [`MCU_IMM_W-1:0]  exit_code_o,
  output logic                   req_o,
  output logic                   we_o,
  output logic [`MCU_ADDR_W-1:0] addr_o,
  output logic [`MCU_DATA_W-1:0] wdata_o,
  input  logic                   gnt_i,
  input  logic                   rvalid_i,
  input  mcu_pkg::mem_word_u     rdata_i
);
  import mcu_pkg::*;

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_FETCH    = 3'd1;
  localparam logic [2:0] S_FETCH_WT = 3'd2;
  localparam logic [2:0] S_ADD_RD   = 3'd3;
  localparam logic [2:0] S_ADD_WT   = 3'd4;
  localparam logic [2:0] S_WRITE    = 3'd5;
  localparam logic [2:0] S_NEXT     = 3'd6;

  logic [2:0]             state_q;
  logic [`MCU_ADDR_W-1:0] pc_q;
  cmd_word_t              cmd_q;
  logic [`MCU_DATA_W-1:0] wdata_q;
  logic [`MCU_DATA_W-1:0] imm_ext;

  assign imm_ext = {{(`MCU_DATA_W - `MCU_IMM_W){1'b0}}, cmd_q.imm};

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= S_IDLE;
      pc_q         <= '0;
      exit_valid_o <= 1'b0;
      exit_code_o  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (run_i) begin
            pc_q         <= '0;
            exit_valid_o <= 1'b0;
            state_q      <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (gnt_i) begin
            state_q <= S_FETCH_WT;
          end
        end
        S_FETCH_WT: begin
          if (rvalid_i) begin
            case (rdata_i.cmd.op)
              CMD_WRITE: state_q <= S_WRITE;
              CMD_ADD:   state_q <= S_ADD_RD;
              CMD_EXIT: begin
                exit_code_o  <= rdata_i.cmd.imm;
                exit_valid_o <= 1'b1;
                state_q      <= S_IDLE;
              end
              // empty words and unknown opcodes fall through as nop
              default:   state_q <= S_NEXT;
            endcase
          end
        end
        S_ADD_RD: begin
          if (gnt_i) begin
            state_q <= S_ADD_WT;
          end
        end
        S_ADD_WT: begin
          if (rvalid_i) begin
            state_q <= S_WRITE;
          end
        end
        S_WRITE: begin
          if (gnt_i) begin
            state_q <= S_NEXT;
          end
        end
        S_NEXT: begin
          // stop rather than wrap back to the start
          if (pc_q == '1) begin
            state_q <= S_IDLE;
          end else begin
            pc_q    <= pc_q + 1'b1;
            state_q <= S_FETCH;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // command and write data registers
  always_ff @(posedge clk_gen) begin
    if (state_q == S_FETCH_WT && rvalid_i) begin
      cmd_q <= rdata_i.cmd;
      wdata_q <= {{(`MCU_DATA_W - `MCU_IMM_W){1'b0}}, rdata_i.cmd.imm};
    end else if (state_q == S_ADD_WT && rvalid_i) begin
      wdata_q <= rdata_i.raw + imm_ext;
    end
  end

  assign running_o = (state_q != S_IDLE);
  assign req_o     = (state_q == S_FETCH) | (state_q == S_ADD_RD) | (state_q == S_WRITE);
  assign we_o      = (state_q == S_WRITE);
  assign addr_o    = (state_q == S_FETCH) ? pc_q : cmd_q.addr;
  assign wdata_o   = wdata_q;

endmodule

`default_nettype wire

//--- hdl/fpga_mcu_wrapper.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FPGA top for the MCU subsystem: board reset, LED heartbeat, exit outputs
// and the loader, engine, arbiter and SRAM instances
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "mcu_macros.svh"

module fpga_mcu_wrapper (
  input  logic                   clk_gen,
  input  logic                   rst_btn_i,
  input  logic                   load_we_i,
  input  logic                   load_rd_i,
  input  logic [`MCU_ADDR_W-1:0] load_addr_i,
  input  logic [`MCU_DATA_W-1:0] load_data_i,
  input  logic                   run_i,
  output logic                   busy_o,
  output logic                   rd_valid_o,
  output logic [`MCU_DATA_W-1:0] rd_data_o,
  output logic                   running_o,
  output logic                   exit_valid_o,
  output logic [`MCU_IMM_W-1:0]  exit_code_o,
  output logic                   exit_value_o,
  output logic                   rst_led_o,
  output logic                   clk_led_o
);

  logic                     rst_n;
  logic [`MCU_LED_CNT_W-1:0] clk_count_q;

  logic                   ldr_req, ldr_we, ldr_gnt, ldr_rvalid;
  logic [`MCU_ADDR_W-1:0] ldr_addr;
  logic [`MCU_DATA_W-1:0] ldr_wdata, ldr_rdata;
  logic                   eng_req, eng_we, eng_gnt, eng_rvalid;
  logic [`MCU_ADDR_W-1:0] eng_addr;
  logic [`MCU_DATA_W-1:0] eng_wdata, eng_rdata;
  logic                   mem_en, mem_we;
  logic [`MCU_ADDR_W-1:0] mem_addr;
  logic [`MCU_DATA_W-1:0] mem_wdata, mem_rdata;

  // internal reset is active low whatever the button polarity
  assign rst_n = `MCU_BOARD_RST_LOW ? rst_btn_i : ~rst_btn_i;

  assign rst_led_o = rst_n;

  // heartbeat
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o    = clk_count_q[`MCU_LED_CNT_W-1];
  assign exit_value_o = exit_code_o[0];

  host_loader host_loader_i (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .load_we_i   (load_we_i),
    .load_rd_i   (load_rd_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .busy_o      (busy_o),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .req_o       (ldr_req),
    .we_o        (ldr_we),
    .addr_o      (ldr_addr),
    .wdata_o     (ldr_wdata),
    .gnt_i       (ldr_gnt),
    .rvalid_i    (ldr_rvalid),
    .rdata_i     (ldr_rdata)
  );

  cmd_engine cmd_engine_i (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .run_i        (run_i),
    .running_o    (running_o),
    .exit_valid_o (exit_valid_o),
    .exit_code_o  (exit_code_o),
    .req_o        (eng_req),
    .we_o         (eng_we),
    .addr_o       (eng_addr),
    .wdata_o      (eng_wdata),
    .gnt_i        (eng_gnt),
    .rvalid_i     (eng_rvalid),
    .rdata_i      (eng_rdata)
  );

  mem_arbiter mem_arbiter_i (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .ldr_req_i    (ldr_req),
    .ldr_we_i     (ldr_we),
    .ldr_addr_i   (ldr_addr),
    .ldr_wdata_i  (ldr_wdata),
    .ldr_gnt_o    (ldr_gnt),
    .ldr_rvalid_o (ldr_rvalid),
    .ldr_rdata_o  (ldr_rdata),
    .eng_req_i    (eng_req),
    .eng_we_i     (eng_we),
    .eng_addr_i   (eng_addr),
    .eng_wdata_i  (eng_wdata),
    .eng_gnt_o    (eng_gnt),
    .eng_rvalid_o (eng_rvalid),
    .eng_rdata_o  (eng_rdata),
    .mem_en_o     (mem_en),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata)
  );

  sram_bank sram_bank_i (
    .clk_gen (clk_gen),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/mcu_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arbiter protocol checker, bound into mem_arbiter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module mcu_chk (
  input logic clk_gen,
  input logic rst_n,
  input logic ldr_req_i,
  input logic eng_req_i,
  input logic ldr_gnt_i,
  input logic eng_gnt_i,
  input logic mem_we_i,
  input logic ldr_rvalid_i,
  input logic eng_rvalid_i
);

  int fail_count = 0;

  grant_onehot: assert property (@(posedge clk_gen) disable iff (!rst_n)
    !(ldr_gnt_i && eng_gnt_i))
    else begin
      fail_count = fail_count + 1;
      $error("both masters granted in one cycle");
    end

  grant_to_requester: assert property (@(posedge clk_gen) disable iff (!rst_n)
    (!ldr_gnt_i || ldr_req_i) && (!eng_gnt_i || eng_req_i))
    else begin
      fail_count = fail_count + 1;
      $error("grant given to a master without a request");
    end

  // losing master keeps asking
  ldr_req_held: assert property (@(posedge clk_gen) disable iff (!rst_n)
    (ldr_req_i && !ldr_gnt_i) |=> ldr_req_i)
    else begin
      fail_count = fail_count + 1;
      $error("loader request dropped before grant");
    end

  eng_req_held: assert property (@(posedge clk_gen) disable iff (!rst_n)
    (eng_req_i && !eng_gnt_i) |=> eng_req_i)
    else begin
      fail_count = fail_count + 1;
      $error("engine request dropped before grant");
    end

  ldr_rvalid_next: assert property (@(posedge clk_gen) disable iff (!rst_n)
    (ldr_gnt_i && !mem_we_i) |=> ldr_rvalid_i)
    else begin
      fail_count = fail_count + 1;
      $error("loader read data not returned one cycle after grant");
    end

  eng_rvalid_next: assert property (@(posedge clk_gen) disable iff (!rst_n)
    (eng_gnt_i && !mem_we_i) |=> eng_rvalid_i)
    else begin
      fail_count = fail_count + 1;
      $error("engine read data not returned one cycle after grant");
    end

endmodule

bind mem_arbiter mcu_chk chk_i (
  .clk_gen      (clk_gen),
  .rst_n        (rst_n),
  .ldr_req_i    (ldr_req_i),
  .eng_req_i    (eng_req_i),
  .ldr_gnt_i    (ldr_gnt_o),
  .eng_gnt_i    (eng_gnt_o),
  .mem_we_i     (mem_we_o),
  .ldr_rvalid_i (ldr_rvalid_o),
  .eng_rvalid_i (eng_rvalid_o)
);

`default_nettype wire

//--- testbench/mcu_scoreboard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scoreboard: reference memory model and checks on the wrapper ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "mcu_macros.svh"

module mcu_scoreboard (
  input logic                   clk_gen,
  input logic                   rst_btn_i,
  input logic                   load_we_i,
  input logic                   load_rd_i,
  input logic [`MCU_ADDR_W-1:0] load_addr_i,
  input logic [`MCU_DATA_W-1:0] load_data_i,
  input logic                   run_i,
  input logic                   busy_i,
  input logic                   rd_valid_i,
  input logic [`MCU_DATA_W-1:0] rd_data_i,
  input logic                   running_i,
  input logic                   exit_valid_i,
  input logic [`MCU_IMM_W-1:0]  exit_code_i,
  input logic                   exit_value_i,
  input logic                   rst_led_i,
  input logic                   clk_led_i
);
  import mcu_pkg::*;

  logic [`MCU_DATA_W-1:0]    model [`MCU_MEM_WORDS];
  logic [`MCU_DATA_W-1:0]    rd_exp_q [$];
  logic [`MCU_LED_CNT_W-1:0] led_cnt;
  logic [`MCU_IMM_W-1:0]     exp_code;
  logic                      exit_pend;
  logic                      exit_prev;
  logic                      clear_chk;
  logic                      rst_exp;
  int                        err_count = 0;
  int                        check_count = 0;

  initial begin
    for (int i = 0; i < `MCU_MEM_WORDS; i++) begin
      model[i] = '0;
    end
    led_cnt   = '0;
    exit_pend = 1'b0;
    exit_prev = 1'b0;
    clear_chk = 1'b0;
    exp_code  = '0;
  end

  task automatic compare(input logic [`MCU_DATA_W-1:0] got, input logic [`MCU_DATA_W-1:0] exp,
                         input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // table expectations against the model
  task automatic check_model(input logic [`MCU_ADDR_W-1:0] addr,
                             input logic [`MCU_DATA_W-1:0] exp);
    compare(model[addr], exp, "reference model word");
  endtask

  function automatic int pending_reads();
    return rd_exp_q.size();
  endfunction

  // executes the whole program on the model until an exit command
  task automatic run_model();
    mem_word_u w;
    for (int pc = 0; pc < `MCU_MEM_WORDS; pc++) begin
      w.raw = model[pc];
      if (w.cmd.op == CMD_EXIT) begin
        exp_code = w.cmd.imm;
        break;
      end else if (w.cmd.op == CMD_WRITE) begin
        model[w.cmd.addr] = {16'h0, w.cmd.imm};
      end else if (w.cmd.op == CMD_ADD) begin
        model[w.cmd.addr] = model[w.cmd.addr] + {16'h0, w.cmd.imm};
      end
    end
  endtask

  always @(negedge clk_gen) begin
    // out of reset while the button rests at its idle level
    rst_exp = (rst_btn_i == `MCU_BOARD_RST_LOW);
    compare({31'h0, rst_led_i}, {31'h0, rst_exp}, "rst_led_o");
    if (!rst_led_i) begin
      compare({26'h0, busy_i, rd_valid_i, running_i, exit_valid_i, exit_value_i, clk_led_i},
              '0, "control outputs in reset");
      compare({16'h0, exit_code_i}, '0, "exit_code_o in reset");
      led_cnt   = '0;
      exit_prev = 1'b0;
      rd_exp_q.delete();
    end else begin
      compare({31'h0, clk_led_i}, {31'h0, led_cnt[`MCU_LED_CNT_W-1]}, "clk_led_o");
      led_cnt = led_cnt + 1'b1;
      if (clear_chk) begin
        compare({31'h0, exit_valid_i}, '0, "exit_valid_o after run");
        clear_chk = 1'b0;
      end
      if (rd_valid_i) begin
        if (rd_exp_q.size() == 0) begin
          err_count++;
          $display("rd_valid_o pulsed at %0t with no read outstanding", $time);
        end else begin
          compare(rd_data_i, rd_exp_q.pop_front(), "rd_data_o");
        end
      end
      if (load_we_i && !busy_i) begin
        model[load_addr_i] = load_data_i;
      end else if (load_rd_i && !busy_i) begin
        rd_exp_q.push_back(model[load_addr_i]);
      end
      // engine busy from the cycle after run until the exit
      if (exit_pend && !exit_valid_i) begin
        compare({31'h0, running_i}, 32'h1, "running_o during run");
      end
      if (exit_valid_i && !exit_prev) begin
        if (!exit_pend) begin
          err_count++;
          $display("exit_valid_o rose at %0t without a run", $time);
        end else begin
          compare({16'h0, exit_code_i}, {16'h0, exp_code}, "exit_code_o");
          compare({31'h0, exit_value_i}, {31'h0, exp_code[0]}, "exit_value_o");
          compare({31'h0, running_i}, '0, "running_o at exit");
        end
        exit_pend = 1'b0;
      end
      exit_prev = exit_valid_i;
      if (run_i && !running_i) begin
        run_model();
        exit_pend = 1'b1;
        clear_chk = 1'b1;
        exit_prev = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_fpga_mcu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the MCU wrapper: step table, watchdog and final verdict
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "mcu_macros.svh"

module tb_fpga_mcu;

  localparam int K_WRITE     = 0;
  localparam int K_READ      = 1;
  localparam int K_RUN       = 2;
  localparam int K_WAIT_EXIT = 3;
  localparam int K_RAND_RD   = 4;
  localparam int MAX_STEPS   = 32;
  localparam logic RST_ON    = `MCU_BOARD_RST_LOW ? 1'b0 : 1'b1;

  logic                   clk_gen;
  logic                   rst_btn;
  logic                   load_we;
  logic                   load_rd;
  logic [`MCU_ADDR_W-1:0] load_addr;
  logic [`MCU_DATA_W-1:0] load_data;
  logic                   run;
  logic                   busy;
  logic                   rd_valid;
  logic [`MCU_DATA_W-1:0] rd_data;
  logic                   running;
  logic                   exit_valid;
  logic [`MCU_IMM_W-1:0]  exit_code;
  logic                   exit_value;
  logic                   rst_led;
  logic                   clk_led;

  int                     step_kind [MAX_STEPS];
  logic [`MCU_ADDR_W-1:0] step_addr [MAX_STEPS];
  logic [`MCU_DATA_W-1:0] step_data [MAX_STEPS];
  int                     n_steps = 0;
  int                     total_err;

  fpga_mcu_wrapper dut_i (
    .clk_gen (clk_gen), .rst_btn_i (rst_btn),
    .load_we_i (load_we), .load_rd_i (load_rd),
    .load_addr_i (load_addr), .load_data_i (load_data),
    .run_i (run), .busy_o (busy), .rd_valid_o (rd_valid), .rd_data_o (rd_data),
    .running_o (running), .exit_valid_o (exit_valid), .exit_code_o (exit_code),
    .exit_value_o (exit_value), .rst_led_o (rst_led), .clk_led_o (clk_led)
  );

  mcu_scoreboard scb_i (
    .clk_gen (clk_gen), .rst_btn_i (rst_btn),
    .load_we_i (load_we), .load_rd_i (load_rd),
    .load_addr_i (load_addr), .load_data_i (load_data),
    .run_i (run), .busy_i (busy), .rd_valid_i (rd_valid), .rd_data_i (rd_data),
    .running_i (running), .exit_valid_i (exit_valid), .exit_code_i (exit_code),
    .exit_value_i (exit_value), .rst_led_i (rst_led), .clk_led_i (clk_led)
  );

  always #2 clk_gen = ~clk_gen;

  task automatic add_step(input int kind, input logic [7:0] addr, input logic [31:0] data);
    step_kind[n_steps] = kind;
    step_addr[n_steps] = addr;
    step_data[n_steps] = data;
    n_steps++;
  endtask

  // hold the strobe until busy_o is low so it is taken exactly once
  task automatic load_access(input logic is_write, input logic [7:0] addr,
                             input logic [31:0] data);
    @(posedge clk_gen);
    load_we   <= is_write;
    load_rd   <= ~is_write;
    load_addr <= addr;
    load_data <= data;
    forever begin
      @(negedge clk_gen);
      if (!busy) break;
    end
    @(posedge clk_gen);
    load_we <= 1'b0;
    load_rd <= 1'b0;
  endtask

  task automatic wait_read_return();
    do @(negedge clk_gen); while (!rd_valid);
  endtask

  task automatic build_table();
    // program: write, add, empty word, add, exit 7
    add_step(K_WRITE, 8'h00, 32'h1040_1234);
    add_step(K_WRITE, 8'h01, 32'h2041_0005);
    add_step(K_WRITE, 8'h02, 32'h0000_0000);
    add_step(K_WRITE, 8'h03, 32'h2040_0001);
    add_step(K_WRITE, 8'h04, 32'h3000_0007);
    add_step(K_WRITE, 8'h41, 32'h0000_0100);
    for (int i = 0; i < 8; i++) begin
      add_step(K_WRITE, 8'h80 + 8'(i), {8'hc3, 8'(i), 16'h5a00 + 16'(i)});
    end
    add_step(K_READ, 8'h80, 32'hc300_5a00);
    add_step(K_READ, 8'h03, 32'h2040_0001);
    add_step(K_RUN, 8'h00, 32'h0);
    add_step(K_RAND_RD, 8'h00, 32'd6);
    add_step(K_WAIT_EXIT, 8'h00, 32'h0);
    add_step(K_READ, 8'h40, 32'h0000_1235);
    add_step(K_READ, 8'h41, 32'h0000_0105);
    add_step(K_READ, 8'h83, 32'hc303_5a03);
    // second run, the add on 0x41 accumulates again
    add_step(K_RUN, 8'h00, 32'h0);
    add_step(K_WAIT_EXIT, 8'h00, 32'h0);
    add_step(K_READ, 8'h41, 32'h0000_010a);
    add_step(K_READ, 8'h40, 32'h0000_1235);
  endtask

  initial begin
    void'($urandom(32'h2243f7f3));
    clk_gen   = 1'b0;
    rst_btn   = RST_ON;
    load_we   = 1'b0;
    load_rd   = 1'b0;
    load_addr = '0;
    load_data = '0;
    run       = 1'b0;
    build_table();
    repeat (5) @(posedge clk_gen);
    rst_btn <= ~RST_ON;
    for (int s = 0; s < n_steps; s++) begin
      case (step_kind[s])
        K_WRITE: load_access(1'b1, step_addr[s], step_data[s]);
        K_READ: begin
          scb_i.check_model(step_addr[s], step_data[s]);
          load_access(1'b0, step_addr[s], '0);
          wait_read_return();
        end
        K_RUN: begin
          @(posedge clk_gen);
          run <= 1'b1;
          @(posedge clk_gen);
          run <= 1'b0;
        end
        K_WAIT_EXIT: begin
          do @(negedge clk_gen); while (!exit_valid);
        end
        default: begin
          for (int r = 0; r < int'(step_data[s]); r++) begin
            load_access(1'b0, 8'h80 + 8'($urandom % 8), '0);
            wait_read_return();
          end
        end
      endcase
    end
    repeat (80) @(posedge clk_gen);
    total_err = scb_i.err_count + dut_i.mem_arbiter_i.chk_i.fail_count + scb_i.pending_reads();
    $display("checks %0d, scoreboard errors %0d, assertion errors %0d, reads left %0d",
             scb_i.check_count, scb_i.err_count, dut_i.mem_arbiter_i.chk_i.fail_count,
             scb_i.pending_reads());
    if (total_err == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog, the table is complete by the first edge
  initial begin
    @(posedge clk_gen);
    repeat (n_steps * 200) @(posedge clk_gen);
    $display("timeout: the run did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- fpga_mcu.f
+incdir+hdl
hdl/mcu_pkg.sv
hdl/mem_arbiter.sv
hdl/sram_bank.sv
hdl/host_loader.sv
hdl/cmd_engine.sv
hdl/fpga_mcu_wrapper.sv
testbench/mcu_chk.sv
testbench/mcu_scoreboard.sv
testbench/tb_fpga_mcu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MCU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpga_mcu -f fpga_mcu.f -o sim_tb

status=0
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  exit "$status"
fi
exit 0
